// File: compile.f
+incdir+verif
logic/ebusPkg.sv
logic/ebusCtl.sv
logic/ebusArbiter.sv
logic/aprUnit.sv
logic/vmaUnit.sv
logic/scdUnit.sv
logic/ebusTop.sv
verif/ebusTb.sv

// File: logic/aprUnit.sv
`timescale 1ns/1ps

// APR status register
// Low bits are sticky error flags, upper bits are control bits

module aprUnit import ebusPkg::*; (
  input  logic                  masterClk,
  input  logic                  reset,
  input  tEbusStrobe            stb,
  input  logic [aprErrBits-1:0] errIn,   // Sampled every edge
  output tEBUSdriver            bus
);

  tEbusData              status;     // Flags in [aprErrBits-1:0]
  logic [aprErrBits-1:0] flagsNext;

  // Flag update
  // A condition clears the masked flags first, then new errors
  // set theirs, so an error at the same edge is never lost
  always_comb begin
    flagsNext = status[aprErrBits-1:0];
    if (stb.cond) begin
      flagsNext = flagsNext & ~stb.data[aprErrBits-1:0];  // Mask clear
    end
    flagsNext = flagsNext | errIn;  // Sticky set
  end

  always_ff @(posedge masterClk) begin
    if (reset) begin
      status <= '0;
    end else begin
      status[aprErrBits-1:0] <= flagsNext;
      if (stb.wr) begin
        // Write only touches control bits
        status[ebusWidth-1:aprErrBits] <= stb.data[ebusWidth-1:aprErrBits];
      end
    end
  end

  // Bus request during the cycle after the read strobe edge
  always_comb begin
    bus.driving = stb.rd;
    bus.data    = status;   // Mux ignores it unless driving
  end

endmodule

// File: logic/ebusArbiter.sv
`timescale 1ns/1ps

// Fixed priority bus mux, APR first then VMA then SCD
// Also flags cycles with more than one driver

module ebusArbiter import ebusPkg::*; (
  input  logic       masterClk,
  input  logic       reset,
  input  tEBUSdriver aprBus,
  input  tEBUSdriver vmaBus,
  input  tEBUSdriver scdBus,
  output tEbusData   ebus,
  output logic       busConflict   // Registered, more than one driver seen
);

  logic [1:0] drvCount;   // Drivers this cycle, 0..3

  // Priority mux, nobody driving reads as zero
  always_comb begin
    if (aprBus.driving)      ebus = aprBus.data;
    else if (vmaBus.driving) ebus = vmaBus.data;
    else if (scdBus.driving) ebus = scdBus.data;
    else                     ebus = '0;
  end

  // Count simultaneous drivers
  always_comb begin
    drvCount = 2'(aprBus.driving) + 2'(vmaBus.driving) + 2'(scdBus.driving);
  end

  always_ff @(posedge masterClk) begin
    if (reset) begin
      busConflict <= 1'b0;
    end else begin
      busConflict <= (drvCount > 2'd1);  // Should never happen
    end
  end

endmodule

// File: logic/ebusCtl.sv
`timescale 1ns/1ps

// Bus controller, turns commands into per-unit strobes
// Read data comes back one edge after the strobe edge

module ebusCtl import ebusPkg::*; (
  input  logic       masterClk,
  input  logic       reset,
  input  tEbusCmd    cmd,       // New command each cycle
  input  tEbusData   ebus,      // Arbitrated bus
  output tEbusStrobe aprStb,
  output tEbusStrobe vmaStb,
  output tEbusStrobe scdStb,
  output tEbusResp   resp
);

  tEbusStrobe stbNext;   // Decoded strobe before unit select
  tEbusStrobe aprNext;
  tEbusStrobe vmaNext;
  tEbusStrobe scdNext;
  logic       rdPend;    // Read strobe is out this cycle

  // Opcode decode, same for every unit
  always_comb begin
    stbNext      = '0;
    stbNext.rd   = (cmd.op == opRead);
    stbNext.wr   = (cmd.op == opWrite);
    stbNext.cond = (cmd.op == opCond);
    stbNext.data = cmd.data;  // Payload rides along
  end

  // Unit select, only the addressed unit sees the strobe
  always_comb begin
    aprNext = '0;
    vmaNext = '0;
    scdNext = '0;
    case (cmd.dev)
      devApr:  aprNext = stbNext;
      devVma:  vmaNext = stbNext;
      devScd:  scdNext = stbNext;
      default: ;                // Unused code, no unit
    endcase
  end

  // Strobe stage, edge E
  always_ff @(posedge masterClk) begin
    if (reset) begin
      aprStb <= '0;
      vmaStb <= '0;
      scdStb <= '0;
      rdPend <= 1'b0;
    end else begin
      aprStb <= aprNext;
      vmaStb <= vmaNext;
      scdStb <= scdNext;
      rdPend <= stbNext.rd;   // Read flag follows strobes
    end
  end

  // Capture stage, edge E+1
  always_ff @(posedge masterClk) begin
    if (reset) begin
      resp <= '0;
    end else begin
      resp.valid <= rdPend;     // One cycle per read
      if (rdPend) begin
        resp.data <= ebus;      // Hold last read otherwise
      end
    end
  end

endmodule

// File: logic/ebusPkg.sv
// Shared types for the diagnostic register bus

package ebusPkg;

  localparam int ebusWidth  = 36;            // Bus word width
  localparam int vmaWidth   = 23;            // VMA address bits
  localparam int scdWidth   = 10;            // SCD shift count bits
  localparam int aprErrBits = 4;             // Sticky APR error flags
  localparam int scdZeroBit = ebusWidth - 1; // SCD zero flag position on read

  // One bus word, bit 0 is the LSB
  typedef logic [ebusWidth-1:0] tEbusData;

  // Command opcode from the outside port
  typedef enum logic [1:0] {
    opNone  = 2'd0,   // Idle cycle
    opRead  = 2'd1,   // Unit drives its register onto the bus
    opWrite = 2'd2,   // Unit loads from data
    opCond  = 2'd3    // Unit-specific condition
  } tEbusOp;

  // Target unit select
  typedef enum logic [1:0] {
    devApr = 2'd0,    // Processor status
    devVma = 2'd1,    // Virtual memory address
    devScd = 2'd2     // Shift count
  } tEbusDev;

  // External command word, one per cycle
  typedef struct packed {
    tEbusOp   op;
    tEbusDev  dev;
    tEbusData data;
  } tEbusCmd;

  // Registered strobe set, one per unit
  typedef struct packed {
    logic     rd;     // Drive register next cycle
    logic     wr;     // Load at next edge
    logic     cond;   // Condition at next edge
    tEbusData data;   // Write data or condition mask
  } tEbusStrobe;

  // One unit's request for the shared bus
  typedef struct packed {
    logic     driving;  // Unit wants the bus
    tEbusData data;     // Unit's bus contents
  } tEBUSdriver;

  // Read result to the outside
  typedef struct packed {
    logic     valid;  // High for one cycle per read
    tEbusData data;
  } tEbusResp;

endpackage

// File: logic/ebusTop.sv
`timescale 1ns/1ps

// Diagnostic bus subsystem top
// Controller, arbiter and the three peer units

module ebusTop import ebusPkg::*; (
  input  logic                  masterClk,
  input  logic                  reset,
  input  tEbusCmd               cmd,          // One command per cycle
  input  logic [aprErrBits-1:0] errIn,        // APR error sources
  output tEbusResp              resp,         // Read results
  output logic                  busConflict   // Multiple drivers seen
);

  tEbusStrobe aprStb;   // Controller to units
  tEbusStrobe vmaStb;
  tEbusStrobe scdStb;
  tEBUSdriver aprBus;   // Units to arbiter
  tEBUSdriver vmaBus;
  tEBUSdriver scdBus;
  tEbusData   ebus;     // Muxed bus

  ebusCtl u_ebusCtl (
    .masterClk (masterClk),
    .reset     (reset),
    .cmd       (cmd),
    .ebus      (ebus),
    .aprStb    (aprStb),
    .vmaStb    (vmaStb),
    .scdStb    (scdStb),
    .resp      (resp)
  );

  ebusArbiter u_ebusArbiter (
    .masterClk   (masterClk),
    .reset       (reset),
    .aprBus      (aprBus),
    .vmaBus      (vmaBus),
    .scdBus      (scdBus),
    .ebus        (ebus),
    .busConflict (busConflict)
  );

  aprUnit u_aprUnit (
    .masterClk (masterClk),
    .reset     (reset),
    .stb       (aprStb),
    .errIn     (errIn),
    .bus       (aprBus)
  );

  vmaUnit u_vmaUnit (
    .masterClk (masterClk),
    .reset     (reset),
    .stb       (vmaStb),
    .bus       (vmaBus)
  );

  scdUnit u_scdUnit (
    .masterClk (masterClk),
    .reset     (reset),
    .stb       (scdStb),
    .bus       (scdBus)
  );

endmodule

// File: logic/scdUnit.sv
`timescale 1ns/1ps

// SCD shift count register
// Load, saturating decrement, zero flag on read

module scdUnit import ebusPkg::*; (
  input  logic       masterClk,
  input  logic       reset,
  input  tEbusStrobe stb,
  output tEBUSdriver bus
);

  logic [scdWidth-1:0] count;   // Shift count
  logic                zero;    // Count is zero

  assign zero = (count == '0);

  always_ff @(posedge masterClk) begin
    if (reset) begin
      count <= '0;
    end else if (stb.wr) begin
      count <= stb.data[scdWidth-1:0];  // Load low bits
    end else if (stb.cond && !zero) begin
      count <= count - 1'b1;            // Stops at zero
    end
  end

  // Read word: count low, zero flag in the top bit
  always_comb begin
    bus.driving             = stb.rd;
    bus.data                = '0;
    bus.data[scdWidth-1:0]  = count;
    bus.data[scdZeroBit]    = zero;
  end

endmodule

// File: logic/vmaUnit.sv
`timescale 1ns/1ps

// VMA address register, load and increment

module vmaUnit import ebusPkg::*; (
  input  logic       masterClk,
  input  logic       reset,
  input  tEbusStrobe stb,
  output tEBUSdriver bus
);

  logic [vmaWidth-1:0] vma;   // Current address

  always_ff @(posedge masterClk) begin
    if (reset) begin
      vma <= '0;
    end else if (stb.wr) begin
      vma <= stb.data[vmaWidth-1:0];  // Upper bus bits dropped
    end else if (stb.cond) begin
      vma <= vma + 1'b1;              // Wraps at 23 bits
    end
  end

  // Read path, zero extended to bus width
  always_comb begin
    bus.driving               = stb.rd;
    bus.data                  = '0;
    bus.data[vmaWidth-1:0]    = vma;
  end

endmodule

// File: verif/ebusModel.svh
`ifndef EBUS_MODEL_SVH
`define EBUS_MODEL_SVH

// Reference model of the three unit registers and the read pipeline
// A command sampled at edge E acts on the registers at edge E+1
// Its read word comes from the registers as they stand after edge E

tEbusData            mApr;      // Status word, flags in the low bits
logic [vmaWidth-1:0] mVma;      // Address
logic [scdWidth-1:0] mScd;      // Shift count
tEbusCmd             stgCmd;    // Command whose strobe is out now
tEbusResp            pendResp;  // Read launched at the last edge
tEbusResp            expResp;   // What resp must show this cycle

// Word a unit puts on the bus for a read
function automatic tEbusData readWord(tEbusDev dev);
  tEbusData w;
  w = '0;
  case (dev)
    devApr: w = mApr;
    devVma: w[vmaWidth-1:0] = mVma;     // Zero extended
    devScd: begin
      w[scdWidth-1:0] = mScd;
      w[ebusWidth-1]  = (mScd == '0);   // Zero flag in the top bit
    end
    default: w = '0;
  endcase
  return w;
endfunction

task automatic modelReset();
  mApr     = '0;
  mVma     = '0;
  mScd     = '0;
  stgCmd   = '0;
  pendResp = '0;
  expResp  = '0;
endtask

// One clock edge, c and err are the values the DUT samples there
task automatic modelStep(tEbusCmd c, logic [aprErrBits-1:0] err);
  logic [aprErrBits-1:0] flags;
  flags = mApr[aprErrBits-1:0];
  if (stgCmd.op == opWrite) begin
    case (stgCmd.dev)
      devApr:  mApr[ebusWidth-1:aprErrBits] = stgCmd.data[ebusWidth-1:aprErrBits];
      devVma:  mVma = stgCmd.data[vmaWidth-1:0];
      devScd:  mScd = stgCmd.data[scdWidth-1:0];
      default: ;
    endcase
  end else if (stgCmd.op == opCond) begin
    case (stgCmd.dev)
      devApr:  flags = flags & ~stgCmd.data[aprErrBits-1:0];  // Masked clear
      devVma:  mVma = mVma + 1'b1;                            // Wraps
      devScd:  mScd = (mScd == '0) ? mScd : mScd - 1'b1;      // Saturates
      default: ;
    endcase
  end
  mApr[aprErrBits-1:0] = flags | err;   // Errors always win
  expResp        = pendResp;            // Second edge of the read
  pendResp.valid = (c.op == opRead);
  pendResp.data  = (c.op == opRead) ? readWord(c.dev) : '0;
  stgCmd         = c;
endtask

`endif

// File: verif/ebusTb.sv
`timescale 1ns/1ps

module ebusTb import ebusPkg::*; ();

  localparam int          numCmds     = 2000;
  localparam int          resetCycles = 5;
  localparam int          cycleLimit  = numCmds + resetCycles + 20;
  localparam int unsigned seed        = 32'h05b0_6f15;

  logic                  masterClk;
  logic                  reset;
  tEbusCmd               cmd;
  logic [aprErrBits-1:0] errIn;
  tEbusResp              resp;
  logic                  busConflict;

  int          cmdsSent     = 0;
  int          cycleCount   = 0;
  bit          modelLive    = 1'b0;   // Model has seen an edge
  int unsigned seedVal;

  `include "ebusModel.svh"

  ebusTop u_ebusTop (
    .masterClk   (masterClk),
    .reset       (reset),
    .cmd         (cmd),
    .errIn       (errIn),
    .resp        (resp),
    .busConflict (busConflict)
  );

  always #50 masterClk = ~masterClk;  // 100 ns period

  task automatic abortRun();
    $display("Test failed");
    $fatal(1, "Run stopped on first error");
  endtask

  task automatic compareResp(tEbusResp expVal, tEbusResp actVal);
    if (actVal.valid !== expVal.valid) begin
      $display("ERR %0t resp.valid expected %0b actual %0b",
               $time, expVal.valid, actVal.valid);
      abortRun();
    end else if (expVal.valid && (actVal.data !== expVal.data)) begin
      $display("ERR %0t resp.data expected %09h actual %09h",
               $time, expVal.data, actVal.data);
      abortRun();
    end
  endtask

  task automatic compareFlag(string name, logic expVal, logic actVal);
    if (actVal !== expVal) begin
      $display("ERR %0t %s expected %0b actual %0b", $time, name, expVal, actVal);
      abortRun();
    end
  endtask

  // Rare single error bit
  function automatic logic [aprErrBits-1:0] sparseErr();
    logic [aprErrBits-1:0] e;
    e = '0;
    if ($urandom_range(15, 0) == 0) begin
      e[$urandom_range(aprErrBits-1, 0)] = 1'b1;
    end
    return e;
  endfunction

  function automatic tEbusCmd makeCmd(tEbusOp op, tEbusDev dev, tEbusData data);
    tEbusCmd c;
    c.op   = op;
    c.dev  = dev;
    c.data = data;
    return c;
  endfunction

  function automatic tEbusCmd randomCmd();
    tEbusCmd c;
    c = '0;
    case ($urandom_range(9, 0))
      0, 1:    c.op = opNone;
      2, 3, 4: c.op = opRead;
      5, 6, 7: c.op = opWrite;
      default: c.op = opCond;
    endcase
    case ($urandom_range(2, 0))
      0:       c.dev = devApr;
      1:       c.dev = devVma;
      default: c.dev = devScd;
    endcase
    c.data = tEbusData'({$urandom, $urandom});  // Upper junk included
    if (c.op == opWrite && $urandom_range(3, 0) == 0) begin
      // Values near the edges so wrap and saturation get hit
      c.data[vmaWidth-1:0] = {vmaWidth{1'b1}} - vmaWidth'($urandom_range(3, 0));
      if (c.dev == devScd) begin
        c.data[scdWidth-1:0] = scdWidth'($urandom_range(3, 0));
      end
    end
    return c;
  endfunction

  // Driven now, sampled by the DUT at the next edge
  task automatic driveCmd(tEbusCmd c);
    cmd   <= c;
    errIn <= sparseErr();
    cmdsSent++;
    @(posedge masterClk);
  endtask

  task automatic directedOpening();
    driveCmd(makeCmd(opRead,  devApr, '0));              // Zero after reset
    driveCmd(makeCmd(opRead,  devVma, '0));
    driveCmd(makeCmd(opRead,  devScd, '0));
    driveCmd(makeCmd(opWrite, devApr, 36'hA_BCDE_F12F));
    driveCmd(makeCmd(opRead,  devApr, '0));              // Right behind the write
    driveCmd(makeCmd(opWrite, devVma, 36'hF_FFFF_FFFF));
    driveCmd(makeCmd(opRead,  devVma, '0));              // Upper bits dropped
    driveCmd(makeCmd(opCond,  devVma, '0));              // Wraps to zero
    driveCmd(makeCmd(opRead,  devVma, '0));
    driveCmd(makeCmd(opWrite, devScd, 36'h8_0000_0002));
    driveCmd(makeCmd(opCond,  devScd, '0));
    driveCmd(makeCmd(opCond,  devScd, '0));
    driveCmd(makeCmd(opCond,  devScd, '0));              // Already zero
    driveCmd(makeCmd(opRead,  devScd, '0));              // Zero flag set
    driveCmd(makeCmd(opCond,  devApr, 36'h0_0000_0005)); // Clear flags 0 and 2
    driveCmd(makeCmd(opRead,  devApr, '0));
  endtask

  // Model steps on the values sampled at the edge
  always @(posedge masterClk) begin
    if (reset) begin
      modelReset();
    end else begin
      modelStep(cmd, errIn);
    end
    modelLive = 1'b1;
  end

  // Outputs are settled at the falling edge
  always @(negedge masterClk) begin
    if (modelLive) begin
      compareResp(expResp, resp);
      compareFlag("busConflict", 1'b0, busConflict);
    end
  end

  always @(posedge masterClk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
      abortRun();
    end
  end

  initial begin
    seedVal   = $urandom(seed);   // Seed once for the whole run
    masterClk = 1'b0;
    reset     = 1'b1;
    cmd       = '0;               // opNone
    errIn     = '0;
    repeat (resetCycles) @(posedge masterClk);
    reset <= 1'b0;
    directedOpening();
    while (cmdsSent < numCmds) begin
      driveCmd(randomCmd());
    end
    cmd   <= '0;
    errIn <= '0;
    // Drain reads still in the pipe
    @(negedge masterClk);
    while (pendResp.valid || expResp.valid) begin
      @(negedge masterClk);
    end
    @(posedge masterClk);
    $display("Test completed successfully");
    $finish;
  end

endmodule
